//--- flist.f
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_alu.sv
source/lc4_hazard_unit.sv
source/lc4_pipeline.sv
verification/lc4_properties.sv
verification/lc4_tb.sv

//--- run.sh
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module lc4_tb -o lc4_sim

output=$(./obj_dir/lc4_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi

//--- verification/lc4_tb.sv
//--------------------------------------------------------------------------
// testbench for the LC4 pipeline: clock, reset, memory models, program,
// golden register and nzp model, retirement checks
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_tb import lc4_pkg::*;;

    localparam word_t BASE_PC     = 16'h8200;
    localparam int    PROG_LEN    = 23;
    localparam int    RESET_CYCLES = 10;
    // reset plus about 16 cycles per instruction, far above the
    // real cost of one cycle per instruction and bubble
    localparam int    MAX_CYCLES  = 400;
    localparam int    NUM_TESTS   = 5;

    logic   gwe;
    logic   i_reset;
    word_t  cur_pc;
    word_t  cur_insn;
    word_t  dmem_addr;
    logic   dmem_we;
    word_t  dmem_wdata;
    word_t  dmem_rdata;
    trace_t trace;

    // program and the two copies of data memory
    word_t  prog [PROG_LEN];
    word_t  dmem [65536];
    word_t  gmem [65536];
    word_t  pc_off;

    // golden state
    word_t  gregs [8];
    nzp_t   gnzp;
    word_t  gpc;

    integer      seed;
    int          cycles;
    int          exp_flush;
    int          exp_load;
    int          retired;
    int          test_errs [NUM_TESTS];
    string       test_names [NUM_TESTS];
    logic [31:0] store_q [$];
    logic        done;

    lc4_pipeline #(
        .P_RESET_PC (BASE_PC)
    ) UUT (
        .gwe          (gwe),
        .i_reset      (i_reset),
        .o_cur_pc     (cur_pc),
        .i_cur_insn   (cur_insn),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_trace      (trace)
    );

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    // instruction memory, NOP outside the program
    assign pc_off   = cur_pc - BASE_PC;
    assign cur_insn = (pc_off < 16'(PROG_LEN)) ? prog[pc_off[4:0]] : 16'h0000;
    // data memory reads in the same cycle
    assign dmem_rdata = dmem[dmem_addr];

    // data memory write, every write is logged for the store checks
    always @(posedge gwe) begin
        if (!i_reset && dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
            store_q.push_back({dmem_addr, dmem_wdata});
        end
    end

    // run limit
    always @(posedge gwe) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: program did not retire within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // instruction encoders
    function automatic word_t enc_const(reg_sel_t d, logic [8:0] imm);
        return {4'b1001, d, imm};
    endfunction

    function automatic word_t enc_rrr(logic [3:0] op, reg_sel_t d, reg_sel_t s,
                                      logic [2:0] sub, reg_sel_t t);
        return {op, d, s, sub, t};
    endfunction

    function automatic word_t enc_addi(reg_sel_t d, reg_sel_t s, logic [4:0] imm);
        return {4'b0001, d, s, 1'b1, imm};
    endfunction

    function automatic word_t enc_mem(logic [3:0] op, reg_sel_t d, reg_sel_t s,
                                      logic [5:0] imm);
        return {op, d, s, imm};
    endfunction

    function automatic word_t enc_br(logic [2:0] mask, logic [8:0] imm);
        return {4'b0000, mask, imm};
    endfunction

    // sign class per the ISA, n high bit, z middle, p low
    function automatic nzp_t sign_class(word_t v);
        if (v[15]) begin
            return 3'b100;
        end
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    function automatic word_t insn_at(word_t pc);
        word_t off;
        off = pc - BASE_PC;
        if (off < 16'(PROG_LEN)) begin
            return prog[off[4:0]];
        end
        return 16'h0000;
    endfunction

    // true when n needs r in execute, store data and NOPs excluded
    function automatic logic needs_reg(word_t n, reg_sel_t r);
        case (n[15:12])
            4'b0001: return n[8:6] == r || (!n[5] && n[2:0] == r);
            4'b0101: return n[8:6] == r || n[2:0] == r;
            4'b0110: return n[8:6] == r;
            4'b0111: return n[8:6] == r;
            4'b0000: return |n[11:9];
            default: return 1'b0;
        endcase
    endfunction

    function automatic int test_of(int idx);
        if (idx <= 6) begin
            return 1;
        end else if (idx <= 9) begin
            return 2;
        end else if (idx <= 12) begin
            return 3;
        end
        return 4;
    endfunction

    task automatic check_eq(input int t, input string what, input word_t exp, input word_t act);
        assert (exp === act) else begin
            $display("Fail %s %s: expected %h, actual %h", test_names[t], what, exp, act);
            test_errs[t]++;
        end
    endtask

    task automatic check_true(input int t, input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s at pc %h", test_names[t], msg, gpc);
            test_errs[t]++;
        end
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("test %s: ok", test_names[t]);
        end else begin
            $display("test %s: %0d errors", test_names[t], test_errs[t]);
        end
    endtask

    // one trace entry, sampled at the falling edge
    task automatic retire_one();
        word_t       insn;
        word_t       a;
        word_t       val;
        word_t       addr;
        word_t       next_pc;
        logic        wr;
        logic [31:0] st;
        int          idx;
        int          t;
        idx = int'(gpc - BASE_PC);
        t   = test_of(idx);
        if (trace.stall == STALL_FLUSH) begin
            check_true(t, !trace.rf_we && !trace.nzp_we, "flush bubble writes state");
            if (exp_flush > 0) begin
                exp_flush--;
            end else begin
                check_true(t, retired == 0, "unexpected flush bubble");
            end
        end else if (trace.stall == STALL_LOAD) begin
            check_true(t, exp_load > 0, "unexpected load-use bubble");
            if (exp_load > 0) begin
                exp_load--;
            end
        end else begin
            check_true(t, exp_flush == 0 && exp_load == 0, "expected bubble is missing");
            exp_flush = 0;
            exp_load  = 0;
            insn      = prog[idx];
            check_eq(t, "pc", gpc, trace.pc);
            check_eq(t, "insn", insn, trace.insn);
            a       = gregs[insn[8:6]];
            wr      = 1'b0;
            val     = 16'h0000;
            next_pc = gpc + 16'd1;
            case (insn[15:12])
                4'b0001: begin
                    wr = 1'b1;
                    if (insn[5]) begin
                        val = a + {{11{insn[4]}}, insn[4:0]};
                    end else if (insn[5:3] == 3'b010) begin
                        val = a - gregs[insn[2:0]];
                    end else begin
                        val = a + gregs[insn[2:0]];
                    end
                end
                4'b0101: begin
                    wr  = 1'b1;
                    val = (insn[5:3] == 3'b010) ? (a | gregs[insn[2:0]]) : (a & gregs[insn[2:0]]);
                end
                4'b1001: begin
                    wr  = 1'b1;
                    val = {{7{insn[8]}}, insn[8:0]};
                end
                4'b0110: begin
                    wr   = 1'b1;
                    addr = a + {{10{insn[5]}}, insn[5:0]};
                    val  = gmem[addr];
                    // the next instruction waits one cycle if it needs the value
                    if (needs_reg(insn_at(next_pc), insn[11:9])) begin
                        exp_load = 1;
                    end
                end
                4'b0111: begin
                    addr       = a + {{10{insn[5]}}, insn[5:0]};
                    gmem[addr] = gregs[insn[11:9]];
                    check_true(t, store_q.size() > 0, "store retired without a memory write");
                    if (store_q.size() > 0) begin
                        st = store_q.pop_front();
                        check_eq(t, "store addr", addr, st[31:16]);
                        check_eq(t, "store data", gregs[insn[11:9]], st[15:0]);
                    end
                end
                default: begin
                    // BR, taken when the mask meets the current nzp
                    if (|(insn[11:9] & gnzp)) begin
                        next_pc   = gpc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
                        exp_flush = 2;
                    end
                end
            endcase
            check_eq(t, "rf_we", {15'd0, wr}, {15'd0, trace.rf_we});
            check_eq(t, "nzp_we", {15'd0, wr}, {15'd0, trace.nzp_we});
            if (wr) begin
                check_eq(t, "rd", {13'd0, insn[11:9]}, {13'd0, trace.rf_wsel});
                check_eq(t, "data", val, trace.rf_wdata);
                check_eq(t, "nzp", {13'd0, sign_class(val)}, {13'd0, trace.nzp_bits});
                gregs[insn[11:9]] = val;
                gnzp              = sign_class(val);
            end
            gpc = next_pc;
            retired++;
            if (idx == 6 || idx == 9 || idx == 12 || idx == PROG_LEN - 1) begin
                report_test(t);
            end
            if (gpc == BASE_PC + 16'(PROG_LEN)) begin
                done = 1'b1;
            end
        end
    endtask

    initial begin
        int failed_tests;
        int failed_checks;
        i_reset   = 1'b1;
        seed      = 32'h89e3562e;
        cycles    = 0;
        exp_flush = 0;
        exp_load  = 0;
        retired   = 0;
        done      = 1'b0;
        gpc       = BASE_PC;
        gnzp      = 3'b000;
        test_names = '{"reset", "alu_chain", "load_use", "store_fwd", "branches"};
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_errs[i] = 0;
        end
        for (int i = 0; i < 8; i++) begin
            gregs[i] = 16'h0000;
        end
        // random contents mixed with the address
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = word_t'($random(seed)) ^ word_t'(a);
            gmem[a] = dmem[a];
        end

        // dependent ALU chain, operands one and two instructions back
        prog[0]  = enc_const(3'd1, 9'd5);
        prog[1]  = enc_const(3'd2, 9'h1fd);
        prog[2]  = enc_rrr(4'b0001, 3'd3, 3'd1, 3'b000, 3'd2);
        prog[3]  = enc_rrr(4'b0001, 3'd4, 3'd3, 3'b010, 3'd1);
        prog[4]  = enc_rrr(4'b0101, 3'd5, 3'd4, 3'b000, 3'd3);
        prog[5]  = enc_rrr(4'b0101, 3'd6, 3'd5, 3'b010, 3'd4);
        prog[6]  = enc_addi(3'd7, 3'd6, 5'd4);
        // load then immediate use
        prog[7]  = enc_const(3'd1, 9'd16);
        prog[8]  = enc_mem(4'b0110, 3'd2, 3'd1, 6'd3);
        prog[9]  = enc_rrr(4'b0001, 3'd3, 3'd2, 3'b000, 3'd1);
        // stores right behind their producers, ALU and load
        prog[10] = enc_mem(4'b0111, 3'd3, 3'd1, 6'd5);
        prog[11] = enc_mem(4'b0110, 3'd4, 3'd1, 6'd5);
        prog[12] = enc_mem(4'b0111, 3'd4, 3'd1, 6'd6);
        // not taken, taken, taken after a load
        prog[13] = enc_const(3'd5, 9'd1);
        prog[14] = enc_br(3'b100, 9'd5);
        prog[15] = enc_br(3'b001, 9'd2);
        prog[16] = enc_const(3'd6, 9'd100);
        prog[17] = enc_const(3'd6, 9'd101);
        prog[18] = enc_mem(4'b0110, 3'd7, 3'd1, 6'd3);
        prog[19] = enc_br(3'b111, 9'd1);
        prog[20] = enc_const(3'd6, 9'd7);
        prog[21] = enc_mem(4'b0110, 3'd0, 3'd1, 6'd6);
        prog[22] = enc_rrr(4'b0001, 3'd1, 3'd0, 3'b000, 3'd0);

        repeat (RESET_CYCLES - 1) @(posedge gwe);
        @(negedge gwe);
        check_eq(0, "pc", BASE_PC, cur_pc);
        check_eq(0, "dmem_we", 16'h0000, {15'd0, dmem_we});
        check_eq(0, "trace writes", 16'h0000, {14'd0, trace.rf_we, trace.nzp_we});
        report_test(0);
        @(posedge gwe);
        i_reset <= 1'b0;

        while (!done) begin
            @(negedge gwe);
            retire_one();
        end

        failed_tests  = 0;
        failed_checks = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            failed_checks += test_errs[i];
            if (test_errs[i] != 0) begin
                failed_tests++;
            end
        end
        $display("tests: %0d, failed tests: %0d, failed checks: %0d, retired: %0d",
                 NUM_TESTS, failed_tests, failed_checks, retired);
        if (failed_checks == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/lc4_properties.sv
//--------------------------------------------------------------------------
// concurrent pipeline rules, bound into the LC4 pipeline top
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_properties import lc4_pkg::*; (
    input wire              gwe,
    input wire              i_reset,
    input wire word_t       i_cur_pc,
    input wire              i_dmem_we,
    input wire trace_t      i_trace,
    input wire stall_kind_e i_x_stall
);

    // no memory write once reset has been seen for a full cycle
    property p_no_write_in_reset;
        @(posedge gwe) (i_reset && $past(i_reset)) |-> !i_dmem_we;
    endproperty

    // flush and reset bubbles change no architectural state
    property p_flush_no_write;
        @(posedge gwe) disable iff (i_reset)
            (i_trace.stall == STALL_FLUSH) |-> (!i_trace.rf_we && !i_trace.nzp_we);
    endproperty

    // a load bubble entering X means fetch refetched the same pc
    property p_stall_holds_pc;
        @(posedge gwe) disable iff (i_reset)
            (i_x_stall == STALL_LOAD) |-> (i_cur_pc == $past(i_cur_pc));
    endproperty

    a_no_write_in_reset: assert property (p_no_write_in_reset)
        else $error("data memory written during reset");

    a_flush_no_write: assert property (p_flush_no_write)
        else $error("flush bubble in trace carries a write");

    a_stall_holds_pc: assert property (p_stall_holds_pc)
        else $error("fetch pc moved during a load stall");

endmodule

bind lc4_pipeline lc4_properties u_properties (
    .gwe       (gwe),
    .i_reset   (i_reset),
    .i_cur_pc  (o_cur_pc),
    .i_dmem_we (o_dmem_we),
    .i_trace   (o_trace),
    .i_x_stall (dx_ctrl_q.stall)
);

`default_nettype wire

//--- source/lc4_pipeline.sv
//--------------------------------------------------------------------------
// five-stage LC4 pipeline top: pc, stage registers, nzp register,
// memory stage and retirement trace register
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_pipeline import lc4_pkg::*; #(
    parameter word_t P_RESET_PC = 16'h8200
) (
    input  wire        gwe,
    input  wire        i_reset,
    output word_t      o_cur_pc,
    input  wire word_t i_cur_insn,
    output word_t      o_dmem_addr,
    output logic       o_dmem_we,
    output word_t      o_dmem_wdata,
    input  wire word_t i_dmem_rdata,
    output trace_t     o_trace
);

    // F/D contents, insn 0 is the NOP used for bubbles
    typedef struct packed {
        word_t       pc;
        word_t       insn;
        stall_kind_e stall;
    } fetch_t;

    // stage payload
    // D/X: op_a rs, op_b rt
    // X/M: op_a alu result or address, op_b store data
    // M/W: op_a alu result, op_b loaded data
    typedef struct packed {
        word_t pc;
        word_t op_a;
        word_t op_b;
    } stage_t;

    word_t       pc_q;
    word_t       pc_next;
    fetch_t      fd_q;
    ctrl_t       dec_ctrl;
    ctrl_t       d_ctrl;
    ctrl_t       dx_ctrl_q;
    ctrl_t       xm_ctrl_q;
    ctrl_t       mw_ctrl_q;
    stage_t      dx_q;
    stage_t      xm_q;
    stage_t      mw_q;
    word_t       rs_data;
    word_t       rt_data;
    word_t       x_rs;
    word_t       x_rt;
    word_t       x_result;
    logic        x_taken;
    nzp_t        nzp_q;
    logic        stall;
    logic        flush;
    bypass_sel_e rs_src;
    bypass_sel_e rt_src;
    bypass_sel_e store_src;
    word_t       wb_data;
    trace_t      trace_q;

    // control with no effect, tagged with the reason for the bubble
    function automatic ctrl_t bubble(stall_kind_e kind);
        ctrl_t c;
        c       = '0;
        c.stall = kind;
        return c;
    endfunction

    // fetch, predicted not taken, redirected by a taken branch in X
    assign pc_next  = flush ? x_result : stall ? pc_q : pc_q + 16'd1;
    assign o_cur_pc = pc_q;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q <= P_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // F/D holds its instruction during a stall
    always_ff @(posedge gwe) begin
        if (i_reset || flush) begin
            fd_q <= '{pc: '0, insn: '0, stall: STALL_FLUSH};
        end else if (!stall) begin
            fd_q <= '{pc: pc_q, insn: i_cur_insn, stall: STALL_NONE};
        end
    end

    // decode
    lc4_decoder u_decoder (
        .i_insn (fd_q.insn),
        .o_ctrl (dec_ctrl)
    );

    // flush bubbles keep their tag from F/D
    always_comb begin
        d_ctrl       = dec_ctrl;
        d_ctrl.stall = fd_q.stall;
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (d_ctrl.rs_sel),
        .i_rt_sel  (d_ctrl.rt_sel),
        .i_rd_sel  (mw_ctrl_q.rd_sel),
        .i_rd_we   (mw_ctrl_q.rd_we),
        .i_rd_data (wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // D/X, bubble on flush or stall
    always_ff @(posedge gwe) begin
        if (i_reset || flush) begin
            dx_ctrl_q <= bubble(STALL_FLUSH);
        end else if (stall) begin
            dx_ctrl_q <= bubble(STALL_LOAD);
        end else begin
            dx_ctrl_q <= d_ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        dx_q <= '{pc: fd_q.pc, op_a: rs_data, op_b: rt_data};
    end

    lc4_hazard_unit u_hazard (
        .i_d_ctrl         (d_ctrl),
        .i_x_ctrl         (dx_ctrl_q),
        .i_m_ctrl         (xm_ctrl_q),
        .i_w_ctrl         (mw_ctrl_q),
        .i_x_branch_taken (x_taken),
        .o_stall          (stall),
        .o_flush          (flush),
        .o_rs_sel         (rs_src),
        .o_rt_sel         (rt_src),
        .o_store_sel      (store_src)
    );

    // execute operand bypass, MX then WX then the decode-time read
    always_comb begin
        case (rs_src)
            BYP_MEM: x_rs = xm_q.op_a;
            BYP_WB:  x_rs = wb_data;
            default: x_rs = dx_q.op_a;
        endcase
        case (rt_src)
            BYP_MEM: x_rt = xm_q.op_a;
            BYP_WB:  x_rt = wb_data;
            default: x_rt = dx_q.op_b;
        endcase
    end

    lc4_alu u_alu (
        .i_ctrl         (dx_ctrl_q),
        .i_pc           (dx_q.pc),
        .i_rs           (x_rs),
        .i_rt           (x_rt),
        .i_nzp          (nzp_q),
        .o_result       (x_result),
        .o_branch_taken (x_taken)
    );

    // nzp: ALU ops set it in X, loads in M
    // the X instruction is younger, so it wins over a load in M
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_q <= '0;
        end else if (dx_ctrl_q.nzp_we && !dx_ctrl_q.is_load) begin
            nzp_q <= nzp_of(x_result);
        end else if (xm_ctrl_q.is_load) begin
            nzp_q <= nzp_of(i_dmem_rdata);
        end
    end

    // X/M
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            xm_ctrl_q <= bubble(STALL_FLUSH);
        end else begin
            xm_ctrl_q <= dx_ctrl_q;
        end
    end

    always_ff @(posedge gwe) begin
        xm_q <= '{pc: dx_q.pc, op_a: x_result, op_b: x_rt};
    end

    // memory stage, data memory answers in the same cycle
    assign o_dmem_we    = xm_ctrl_q.is_store;
    assign o_dmem_addr  = (xm_ctrl_q.is_load || xm_ctrl_q.is_store) ? xm_q.op_a : '0;
    // WM bypass of the store data
    assign o_dmem_wdata = (store_src == BYP_WB) ? wb_data : xm_q.op_b;

    // M/W
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            mw_ctrl_q <= bubble(STALL_FLUSH);
        end else begin
            mw_ctrl_q <= xm_ctrl_q;
        end
    end

    always_ff @(posedge gwe) begin
        mw_q <= '{pc: xm_q.pc, op_a: xm_q.op_a, op_b: i_dmem_rdata};
    end

    // writeback value
    assign wb_data = mw_ctrl_q.is_load ? mw_q.op_b : mw_q.op_a;

    // trace latched on the same edge as the regfile write
    // nzp of every writer is the sign of its writeback value
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            trace_q       <= '0;
            trace_q.stall <= STALL_FLUSH;
        end else begin
            trace_q <= '{
                pc:       mw_q.pc,
                insn:     mw_ctrl_q.insn,
                rf_we:    mw_ctrl_q.rd_we,
                rf_wsel:  mw_ctrl_q.rd_sel,
                rf_wdata: mw_ctrl_q.rd_we ? wb_data : '0,
                nzp_we:   mw_ctrl_q.nzp_we,
                nzp_bits: mw_ctrl_q.nzp_we ? nzp_of(wb_data) : '0,
                stall:    mw_ctrl_q.stall
            };
        end
    end

    assign o_trace = trace_q;

endmodule

`default_nettype wire

//--- source/lc4_hazard_unit.sv
//--------------------------------------------------------------------------
// hazard unit: load-use and load-branch stalls, branch flush,
// operand and store-data bypass selection
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit import lc4_pkg::*; (
    input  wire ctrl_t  i_d_ctrl,
    input  wire ctrl_t  i_x_ctrl,
    input  wire ctrl_t  i_m_ctrl,
    input  wire ctrl_t  i_w_ctrl,
    input  wire         i_x_branch_taken,
    output logic        o_stall,
    output logic        o_flush,
    output bypass_sel_e o_rs_sel,
    output bypass_sel_e o_rt_sel,
    output bypass_sel_e o_store_sel
);

    logic x_load;
    logic load_use;
    logic load_branch;
    logic store_match;

    // youngest producer wins, loads in M only have an address so far
    function automatic bypass_sel_e pick_src(reg_sel_t sel, ctrl_t m, ctrl_t w);
        if (m.rd_we && !m.is_load && m.rd_sel == sel) begin
            return BYP_MEM;
        end
        if (w.rd_we && w.rd_sel == sel) begin
            return BYP_WB;
        end
        return BYP_REG;
    endfunction

    assign x_load = i_x_ctrl.is_load && i_x_ctrl.rd_we;

    // store data is exempt, it is picked up again in the memory stage
    assign load_use = x_load &&
        ((i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel) ||
         (i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt_sel == i_x_ctrl.rd_sel));

    // load writes nzp only at the end of M, branch must wait one cycle
    assign load_branch = i_d_ctrl.is_branch && i_x_ctrl.is_load;

    // taken branch kills D and F, so any stall it meets is moot
    assign o_flush = i_x_branch_taken;
    assign o_stall = (load_use || load_branch) && !o_flush;

    // execute operands
    assign o_rs_sel = pick_src(i_x_ctrl.rs_sel, i_m_ctrl, i_w_ctrl);
    assign o_rt_sel = pick_src(i_x_ctrl.rt_sel, i_m_ctrl, i_w_ctrl);

    // store data in M, covers a load directly ahead of the store
    assign store_match = i_m_ctrl.is_store && i_w_ctrl.rd_we &&
                         i_w_ctrl.rd_sel == i_m_ctrl.rt_sel;
    assign o_store_sel = store_match ? BYP_WB : BYP_REG;

endmodule

`default_nettype wire

//--- source/lc4_alu.sv
//--------------------------------------------------------------------------
// execute stage: register and immediate arithmetic, load/store address,
// branch target and branch decision
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_alu import lc4_pkg::*; (
    input  wire ctrl_t i_ctrl,
    input  wire word_t i_pc,
    input  wire word_t i_rs,
    input  wire word_t i_rt,
    input  wire nzp_t  i_nzp,
    output word_t      o_result,
    output logic       o_branch_taken
);

    opcode_e opcode;
    subop_t  subop;
    word_t   imm5;
    word_t   imm6;
    word_t   imm9;

    assign opcode = opcode_e'(i_ctrl.insn[15:12]);
    assign subop  = i_ctrl.insn[5:3];

    // sign-extended immediates
    assign imm5 = {{11{i_ctrl.insn[4]}}, i_ctrl.insn[4:0]};
    assign imm6 = {{10{i_ctrl.insn[5]}}, i_ctrl.insn[5:0]};
    assign imm9 = {{7{i_ctrl.insn[8]}}, i_ctrl.insn[8:0]};

    always_comb begin
        case (opcode)
            OP_ARITH: begin
                if (i_ctrl.insn[5]) begin
                    o_result = i_rs + imm5;
                end else if (subop == SUB_SUB) begin
                    o_result = i_rs - i_rt;
                end else begin
                    o_result = i_rs + i_rt;
                end
            end
            // AND unless the sub-op says OR
            OP_LOGIC: o_result = (subop == SUB_OR) ? (i_rs | i_rt) : (i_rs & i_rt);
            // effective address for the memory stage
            OP_LDR:   o_result = i_rs + imm6;
            OP_STR:   o_result = i_rs + imm6;
            OP_CONST: o_result = imm9;
            // target is relative to the next sequential pc
            OP_BR:    o_result = i_pc + 16'd1 + imm9;
            default:  o_result = '0;
        endcase
    end

    // taken when the mask selects any currently set condition
    assign o_branch_taken = i_ctrl.is_branch && |(i_ctrl.insn[11:9] & i_nzp);

endmodule

`default_nettype wire

//--- source/lc4_regfile.sv
//--------------------------------------------------------------------------
// eight-entry register file, two read ports, one write port
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
    input  wire           gwe,
    input  wire           i_reset,
    input  wire reg_sel_t i_rs_sel,
    input  wire reg_sel_t i_rt_sel,
    input  wire reg_sel_t i_rd_sel,
    input  wire           i_rd_we,
    input  wire word_t    i_rd_data,
    output word_t         o_rs_data,
    output word_t         o_rt_data
);

    word_t regs [8];

    // written from writeback
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // a read of the register being written sees the new value
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- source/lc4_decoder.sv
//--------------------------------------------------------------------------
// instruction decoder, fills the control struct for the D/X register
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder import lc4_pkg::*; (
    input  wire word_t i_insn,
    output ctrl_t      o_ctrl
);

    opcode_e opcode;
    subop_t  subop;

    assign opcode = opcode_e'(i_insn[15:12]);
    assign subop  = i_insn[5:3];

    always_comb begin
        // default is a NOP, no reads and no writes
        o_ctrl        = '0;
        o_ctrl.insn   = i_insn;
        o_ctrl.stall  = STALL_NONE;
        // fixed field positions, rt moves for STR below
        o_ctrl.rs_sel = i_insn[8:6];
        o_ctrl.rt_sel = i_insn[2:0];
        o_ctrl.rd_sel = i_insn[11:9];

        case (opcode)
            OP_ARITH: begin
                if (i_insn[5]) begin
                    // ADDI, rs plus imm5
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end else if (subop == SUB_ADD || subop == SUB_SUB) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                // immediate AND and the other sub-ops stay NOPs
                if (!i_insn[5] && (subop == SUB_AND || subop == SUB_OR)) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                // store data register sits in the rd field
                o_ctrl.rt_sel   = i_insn[11:9];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            OP_BR: begin
                // empty nzp mask is the NOP and never branches
                o_ctrl.is_branch = |i_insn[11:9];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/lc4_pkg.sv
//--------------------------------------------------------------------------
// shared LC4 types: word widths, opcodes, stall kinds, bypass choices,
// decoded control and retirement trace structs, nzp helper
//--------------------------------------------------------------------------
`default_nettype none

package lc4_pkg;

    // data, address and instruction words
    typedef logic [15:0] word_t;
    // register number, r0 to r7
    typedef logic [2:0] reg_sel_t;
    // condition codes, n in bit 2, z in bit 1, p in bit 0
    typedef logic [2:0] nzp_t;
    // sub-op field insn[5:3] of the register forms
    typedef logic [2:0] subop_t;

    // top four bits of an instruction
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    // arithmetic sub-ops
    localparam subop_t SUB_ADD = 3'b000;
    localparam subop_t SUB_SUB = 3'b010;
    // logic sub-ops
    localparam subop_t SUB_AND = 3'b000;
    localparam subop_t SUB_OR  = 3'b010;

    // stall code carried down the pipe and shown in the trace
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_kind_e;

    // where an execute or store operand is taken from
    typedef enum logic [1:0] {
        BYP_REG,
        BYP_MEM,
        BYP_WB
    } bypass_sel_e;

    // decoded control, travels with the instruction from D to W
    typedef struct packed {
        word_t       insn;
        reg_sel_t    rs_sel;
        reg_sel_t    rt_sel;
        reg_sel_t    rd_sel;
        logic        rs_re;
        logic        rt_re;
        logic        rd_we;
        logic        nzp_we;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        stall_kind_e stall;
    } ctrl_t;

    // one retired instruction or bubble
    typedef struct packed {
        word_t       pc;
        word_t       insn;
        logic        rf_we;
        reg_sel_t    rf_wsel;
        word_t       rf_wdata;
        logic        nzp_we;
        nzp_t        nzp_bits;
        stall_kind_e stall;
    } trace_t;

    // sign class of a 16-bit two's complement value
    function automatic nzp_t nzp_of(word_t v);
        return v[15] ? 3'b100 : (v == '0) ? 3'b010 : 3'b001;
    endfunction

endpackage

`default_nettype wire
